// File: common/bank_pkg.sv
package bank_pkg;

  // number of word-interleaved banks, power of two
  parameter int unsigned NB_BANKS = 8;

  // 32-bit words in each bank
  parameter int unsigned BANK_WORDS = 64;

  // address bits 4:2 pick the bank
  parameter int unsigned BANK_SEL_W = $clog2(NB_BANKS);

  // row address inside one bank
  parameter int unsigned ROW_W = $clog2(BANK_WORDS);

  // row field starts right above byte offset and bank index
  parameter int unsigned ROW_LSB = BANK_SEL_W + 2;

endpackage

// File: common/tcdm_pkg.sv
package tcdm_pkg;

  // width of the wide initiator port
  parameter int unsigned WIDE_DW = 128;

  // width of one lane, equal to one bank word
  parameter int unsigned LANE_DW = 32;

  // lanes per wide word
  parameter int unsigned NB_LANES = WIDE_DW / LANE_DW;

  // byte address width on the wide port
  parameter int unsigned ADDR_W = 32;

  // one enable bit per byte of the wide word
  typedef logic [WIDE_DW/8-1:0] wide_be_t;

  // one enable bit per byte of a lane
  typedef logic [LANE_DW/8-1:0] lane_be_t;

endpackage

// File: router/router_reorder.sv
`timescale 1ns/1ps

module router_reorder #(
  parameter int unsigned NB_LANES = tcdm_pkg::NB_LANES,
  parameter int unsigned NB_BANKS = bank_pkg::NB_BANKS
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic [$clog2(NB_BANKS)-1:0]                  order_i,
  input  logic [NB_LANES-1:0]                          lane_req_i,
  input  logic [NB_LANES-1:0]                          lane_wen_i,
  input  logic [NB_LANES-1:0][bank_pkg::ROW_W-1:0]     lane_row_i,
  input  tcdm_pkg::lane_be_t [NB_LANES-1:0]            lane_be_i,
  input  logic [NB_LANES-1:0][tcdm_pkg::LANE_DW-1:0]   lane_wdata_i,
  output logic [NB_LANES-1:0]                          lane_gnt_o,
  output logic [NB_LANES-1:0]                          lane_rvalid_o,
  output logic [NB_LANES-1:0][tcdm_pkg::LANE_DW-1:0]   lane_rdata_o,
  output logic [NB_BANKS-1:0]                          bank_req_o,
  output logic [NB_BANKS-1:0]                          bank_wen_o,
  output logic [NB_BANKS-1:0][bank_pkg::ROW_W-1:0]     bank_row_o,
  output tcdm_pkg::lane_be_t [NB_BANKS-1:0]            bank_be_o,
  output logic [NB_BANKS-1:0][tcdm_pkg::LANE_DW-1:0]   bank_wdata_o,
  input  logic [NB_BANKS-1:0]                          bank_gnt_i,
  input  logic [NB_BANKS-1:0]                          bank_rvalid_i,
  input  logic [NB_BANKS-1:0][tcdm_pkg::LANE_DW-1:0]   bank_rdata_i
);

  localparam int unsigned SEL_W = $clog2(NB_BANKS);

  // offset of the word whose responses are due this cycle
  logic [SEL_W-1:0] order_q;

  // lane l drives bank order_i+l, untouched banks stay idle
  always_comb begin
    logic [SEL_W-1:0] idx;
    bank_req_o   = '0;
    bank_wen_o   = '0;
    bank_row_o   = '0;
    bank_be_o    = '0;
    bank_wdata_o = '0;
    for (int l = 0; l < NB_LANES; l++) begin
      // index wraps modulo the power-of-two bank count
      idx               = order_i + SEL_W'(l);
      bank_req_o[idx]   = lane_req_i[l];
      bank_wen_o[idx]   = lane_wen_i[l];
      bank_row_o[idx]   = lane_row_i[l];
      bank_be_o[idx]    = lane_be_i[l];
      bank_wdata_o[idx] = lane_wdata_i[l];
    end
  end

  for (genvar l = 0; l < NB_LANES; l++) begin : gen_rsp
    // grant comes back in the request cycle, so current offset
    assign lane_gnt_o[l]    = bank_gnt_i[order_i + SEL_W'(l)];
    // data belongs to the word granted a cycle earlier
    assign lane_rvalid_o[l] = bank_rvalid_i[order_q + SEL_W'(l)];
    assign lane_rdata_o[l]  = bank_rdata_i[order_q + SEL_W'(l)];
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      order_q <= '0;
    end else if (lane_req_i[0] && lane_gnt_o[0]) begin
      order_q <= order_i;
    end
  end

endmodule

// File: router/wide_router.sv
`timescale 1ns/1ps

module wide_router #(
  parameter int unsigned NB_BANKS = bank_pkg::NB_BANKS
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         req_i,
  input  logic                                         wen_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]                  addr_i,
  input  tcdm_pkg::wide_be_t                           be_i,
  input  logic [tcdm_pkg::WIDE_DW-1:0]                 wdata_i,
  output logic                                         gnt_o,
  output logic                                         rvalid_o,
  output logic [tcdm_pkg::WIDE_DW-1:0]                 rdata_o,
  output logic [NB_BANKS-1:0]                          bank_req_o,
  output logic [NB_BANKS-1:0]                          bank_wen_o,
  output logic [NB_BANKS-1:0][bank_pkg::ROW_W-1:0]     bank_row_o,
  output tcdm_pkg::lane_be_t [NB_BANKS-1:0]            bank_be_o,
  output logic [NB_BANKS-1:0][tcdm_pkg::LANE_DW-1:0]   bank_wdata_o,
  input  logic [NB_BANKS-1:0]                          bank_gnt_i,
  input  logic [NB_BANKS-1:0]                          bank_rvalid_i,
  input  logic [NB_BANKS-1:0][tcdm_pkg::LANE_DW-1:0]   bank_rdata_i
);
  import tcdm_pkg::*;
  import bank_pkg::*;

  // lane-side view of the wide word
  logic [NB_LANES-1:0]              lane_req;
  logic [NB_LANES-1:0]              lane_wen;
  logic [NB_LANES-1:0][ROW_W-1:0]   lane_row;
  lane_be_t [NB_LANES-1:0]          lane_be;
  logic [NB_LANES-1:0][LANE_DW-1:0] lane_wdata;
  logic [NB_LANES-1:0]              lane_gnt;
  logic [NB_LANES-1:0]              lane_rvalid;
  logic [NB_LANES-1:0][LANE_DW-1:0] lane_rdata;

  logic [BANK_SEL_W-1:0] bank_offset;
  logic [ROW_W-1:0]      row_base;
  logic                  gnt_q;

  // bank of lane 0 and the row shared by the unwrapped lanes
  assign bank_offset = addr_i[ROW_LSB-1:2];
  assign row_base    = addr_i[ROW_LSB +: ROW_W];

  for (genvar i = 0; i < NB_LANES; i++) begin : gen_lane
    // every lane follows the single wide handshake
    assign lane_req[i]   = req_i;
    assign lane_wen[i]   = wen_i;
    assign lane_be[i]    = be_i[i*(LANE_DW/8) +: LANE_DW/8];
    assign lane_wdata[i] = wdata_i[i*LANE_DW +: LANE_DW];
    assign rdata_o[i*LANE_DW +: LANE_DW] = lane_rdata[i];

    // lanes that run past the last bank land in the next row
    always_comb begin
      if (int'(bank_offset) + i >= NB_BANKS) begin
        lane_row[i] = row_base + 1'b1;
      end else begin
        lane_row[i] = row_base;
      end
    end
  end

  // lane 0 stands for the whole word as all lanes are granted together
  assign gnt_o = lane_gnt[0] & lane_req[0];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_q <= 1'b0;
    end else begin
      gnt_q <= gnt_o;
    end
  end

  // response is only taken in the cycle after our own grant
  assign rvalid_o = lane_rvalid[0] & gnt_q;

  router_reorder #(
    .NB_LANES ( NB_LANES ),
    .NB_BANKS ( NB_BANKS )
  ) u_reorder (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .order_i       ( bank_offset   ),
    .lane_req_i    ( lane_req      ),
    .lane_wen_i    ( lane_wen      ),
    .lane_row_i    ( lane_row      ),
    .lane_be_i     ( lane_be       ),
    .lane_wdata_i  ( lane_wdata    ),
    .lane_gnt_o    ( lane_gnt      ),
    .lane_rvalid_o ( lane_rvalid   ),
    .lane_rdata_o  ( lane_rdata    ),
    .bank_req_o    ( bank_req_o    ),
    .bank_wen_o    ( bank_wen_o    ),
    .bank_row_o    ( bank_row_o    ),
    .bank_be_o     ( bank_be_o     ),
    .bank_wdata_o  ( bank_wdata_o  ),
    .bank_gnt_i    ( bank_gnt_i    ),
    .bank_rvalid_i ( bank_rvalid_i ),
    .bank_rdata_i  ( bank_rdata_i  )
  );

  // banks answer every grant on the next cycle
  a_gnt_rvalid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    gnt_o |=> rvalid_o);
  // no lane sees a bank response without a grant in the cycle before
  a_rvalid_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    |lane_rvalid |-> gnt_q);

  // a partial grant would split the wide word across cycles
  a_lanes_gnt: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (&lane_gnt || !(|lane_gnt)));

endmodule

// File: run_sim.sh
#!/bin/sh
# compile and run the wide TCDM testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_wide_tcdm -Mdir obj_dir -f wide_tcdm.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/Vtb_wide_tcdm)
status=$?
printf '%s\n' "$output"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the testbench prints the pass line only when every check held
if printf '%s\n' "$output" | grep -qx "No errors"; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

// File: sim/tb_wide_tcdm.sv
`timescale 1ns/1ps

module tb_wide_tcdm;
  import tcdm_pkg::*;
  import bank_pkg::*;

  localparam int unsigned MODEL_WORDS  = NB_BANKS * BANK_WORDS;
  localparam int unsigned WORD_W       = $clog2(MODEL_WORDS);
  localparam int unsigned RESET_CYCLES = 3;
  // transactions per test sized for the watchdog budget
  localparam int unsigned INIT_TXN  = MODEL_WORDS / NB_LANES;
  localparam int unsigned T2_TXN    = 16;
  localparam int unsigned T3_TXN    = 22;
  localparam int unsigned T4_TXN    = 24;
  localparam int unsigned T5_TXN    = 300 + 40;
  localparam int unsigned TOTAL_TXN = INIT_TXN + T2_TXN + T3_TXN + T4_TXN + T5_TXN;
  localparam int unsigned WATCHDOG_CYCLES = RESET_CYCLES + 20 * TOTAL_TXN;

  logic               clk_i, rst_ni;
  logic               wide_req_i, wide_wen_i;
  logic [ADDR_W-1:0]  wide_addr_i;
  wide_be_t           wide_be_i;
  logic [WIDE_DW-1:0] wide_wdata_i;
  logic               wide_gnt_o, wide_rvalid_o;
  logic [WIDE_DW-1:0] wide_rdata_o;

  // reference copy of all banks indexed by global word
  logic [LANE_DW-1:0] ref_mem [MODEL_WORDS];
  // top bit marks a read and the rest is its expected data
  logic [WIDE_DW:0]   pending_q [$];
  int unsigned        data_errors, proto_errors, stall_cycles;

  wide_tcdm_top #(
    .FIFO_DEPTH ( 2          ),
    .NB_BANKS   ( NB_BANKS   ),
    .BANK_WORDS ( BANK_WORDS )
  ) u_wide_tcdm_top (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .wide_req_i    ( wide_req_i    ),
    .wide_wen_i    ( wide_wen_i    ),
    .wide_addr_i   ( wide_addr_i   ),
    .wide_be_i     ( wide_be_i     ),
    .wide_wdata_i  ( wide_wdata_i  ),
    .wide_gnt_o    ( wide_gnt_o    ),
    .wide_rvalid_o ( wide_rvalid_o ),
    .wide_rdata_o  ( wide_rdata_o  )
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // initial content where every bit of the word index shows up
  function automatic logic [LANE_DW-1:0] fill_word(input int unsigned w);
    logic [8:0] idx;
    idx = 9'(w);
    return {7'h2a, idx, 7'h15, ~idx};
  endfunction

  function automatic logic [WIDE_DW-1:0] rand_wide();
    return {$urandom(), $urandom(), $urandom(), $urandom()};
  endfunction

  // expected memory behavior where lane i sits one word above lane i-1
  function automatic logic [WIDE_DW-1:0] model_access(input logic wen,
      input logic [ADDR_W-1:0] addr, input wide_be_t be, input logic [WIDE_DW-1:0] wdata);
    logic [WIDE_DW-1:0] rdata;
    logic [WORD_W-1:0]  word;
    rdata = '0;
    for (int i = 0; i < NB_LANES; i++) begin
      // truncation wraps past the last word back to word 0
      word = WORD_W'((addr >> 2) + ADDR_W'(i));
      if (wen) begin
        rdata[i*LANE_DW +: LANE_DW] = ref_mem[word];
      end else begin
        for (int b = 0; b < LANE_DW / 8; b++) begin
          if (be[i*(LANE_DW/8) + b]) begin
            ref_mem[word][b*8 +: 8] = wdata[i*LANE_DW + b*8 +: 8];
          end
        end
      end
    end
    return rdata;
  endfunction

  // drive one request and hold it until granted
  task automatic issue(input logic wen, input logic [ADDR_W-1:0] addr, input wide_be_t be,
                       input logic [WIDE_DW-1:0] wdata);
    logic [WIDE_DW-1:0] exp;
    @(posedge clk_i);
    wide_req_i   <= 1'b1;
    wide_wen_i   <= wen;
    wide_addr_i  <= addr;
    wide_be_i    <= be;
    wide_wdata_i <= wdata;
    @(negedge clk_i);
    while (!wide_gnt_o) begin
      stall_cycles++;
      @(negedge clk_i);
    end
    // transfer happens on the coming edge so the model steps in the same order
    exp = model_access(wen, addr, be, wdata);
    pending_q.push_back({wen, exp});
  endtask

  task automatic idle_bus(input int unsigned cycles);
    @(posedge clk_i);
    wide_req_i <= 1'b0;
    repeat (cycles - 1) @(posedge clk_i);
  endtask

  // every rvalid retires the oldest request and writes carry no data
  always @(negedge clk_i) begin : compare_rsp
    logic [WIDE_DW:0] entry;
    if (rst_ni && wide_rvalid_o) begin
      assert (pending_q.size() != 0) else begin
        $display("extra response at %0t with no request outstanding", $time);
        proto_errors++;
      end
      if (pending_q.size() != 0) begin
        entry = pending_q.pop_front();
        assert (!entry[WIDE_DW] || wide_rdata_o === entry[WIDE_DW-1:0]) else begin
          $display("FAILED at %0t: read data %h, expected %h", $time, wide_rdata_o,
                   entry[WIDE_DW-1:0]);
          data_errors++;
        end
      end
    end
  end

  initial begin
    logic [WIDE_DW-1:0] data;
    int unsigned        wait_cycles;
    void'($urandom(25));
    data_errors  = 0;
    proto_errors = 0;
    stall_cycles = 0;
    rst_ni       = 1'b0;
    wide_req_i   = 1'b0;
    wide_wen_i   = 1'b0;
    wide_addr_i  = '0;
    wide_be_i    = '0;
    wide_wdata_i = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;

    // test 1 checks that a quiet bus gives no responses
    repeat (10) begin
      @(negedge clk_i);
      assert (!wide_rvalid_o) else begin
        $display("response seen at %0t while no request was made", $time);
        proto_errors++;
      end
    end

    // known content in every word before anything is read
    for (int k = 0; k < INIT_TXN; k++) begin
      for (int i = 0; i < NB_LANES; i++) begin
        data[i*LANE_DW +: LANE_DW] = fill_word(k * NB_LANES + i);
      end
      issue(1'b0, ADDR_W'(k * 16), '1, data);
    end

    // test 2 with aligned words at bank offset 0
    for (int k = 0; k < 8; k++) issue(1'b0, ADDR_W'(k * 160), '1, rand_wide());
    for (int k = 0; k < 8; k++) issue(1'b1, ADDR_W'(k * 160), '0, '0);

    // test 3 where offsets 5 to 7 spill into the next row and row 63 wraps to row 0
    issue(1'b0, ADDR_W'(20 * 32 + 5 * 4), '1, rand_wide());
    issue(1'b0, ADDR_W'(21 * 32 + 6 * 4), '1, rand_wide());
    issue(1'b0, ADDR_W'(63 * 32 + 7 * 4), '1, rand_wide());
    issue(1'b1, ADDR_W'(20 * 32 + 5 * 4), '0, '0);
    issue(1'b1, ADDR_W'(21 * 32 + 6 * 4), '0, '0);
    issue(1'b1, ADDR_W'(63 * 32 + 7 * 4), '0, '0);
    // word-aligned reads that straddle the wrapped lanes
    for (int j = 0; j < 16; j++) issue(1'b1, ADDR_W'(20 * 32 + j * 4), '0, '0);

    // test 4 reads each partial write straight back
    for (int k = 0; k < T4_TXN / 2; k++) begin
      data = {21'b0, WORD_W'($urandom_range(0, MODEL_WORDS - 1)), 2'b00};
      issue(1'b0, data[ADDR_W-1:0], wide_be_t'($urandom()), rand_wide());
      issue(1'b1, data[ADDR_W-1:0], '0, '0);
    end

    // test 5 mixes random requests and gaps before a gapless burst
    for (int k = 0; k < 300; k++) begin
      data = {21'b0, WORD_W'($urandom_range(0, MODEL_WORDS - 1)), 2'b00};
      issue(1'($urandom()), data[ADDR_W-1:0], wide_be_t'($urandom()), rand_wide());
      wait_cycles = $urandom_range(0, 3);
      if (wait_cycles != 0) idle_bus(wait_cycles);
    end
    stall_cycles = 0;
    for (int k = 0; k < 40; k++) begin
      data = {21'b0, WORD_W'($urandom_range(0, MODEL_WORDS - 1)), 2'b00};
      issue(1'($urandom()), data[ADDR_W-1:0], wide_be_t'($urandom()), rand_wide());
    end
    // the router takes the FIFO head every cycle so the FIFO never fills
    assert (stall_cycles == 0) else begin
      $display("wide_gnt_o dropped for %0d cycles in a burst the router drains",
               stall_cycles);
      proto_errors++;
    end
    idle_bus(1);

    // every request must get its response
    wait_cycles = 0;
    while (pending_q.size() != 0 && wait_cycles < 50) begin
      @(negedge clk_i);
      wait_cycles++;
    end
    assert (pending_q.size() == 0) else begin
      $display("%0d responses never arrived", pending_q.size());
      proto_errors++;
    end
    // late stray responses still count
    repeat (5) @(negedge clk_i);

    $display("data errors: %0d, protocol errors: %0d", data_errors, proto_errors);
    if (data_errors + proto_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("timeout after %0d cycles with %0d responses pending", WATCHDOG_CYCLES,
             pending_q.size());
    $display("Errors found");
    $finish;
  end

endmodule

// File: src/tcdm_bank.sv
`timescale 1ns/1ps

module tcdm_bank #(
  parameter int unsigned BANK_WORDS = bank_pkg::BANK_WORDS
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic                           wen_i,
  input  logic [bank_pkg::ROW_W-1:0]     row_i,
  input  tcdm_pkg::lane_be_t             be_i,
  input  logic [tcdm_pkg::LANE_DW-1:0]   wdata_i,
  output logic                           gnt_o,
  output logic                           rvalid_o,
  output logic [tcdm_pkg::LANE_DW-1:0]   rdata_o
);
  import tcdm_pkg::*;

  logic [LANE_DW-1:0] mem_q [BANK_WORDS];
  logic [LANE_DW-1:0] rdata_q;
  logic               rvalid_q;

  // single-ported sram never stalls
  assign gnt_o = req_i;

  always_ff @(posedge clk_i) begin
    if (req_i && gnt_o) begin
      if (wen_i) begin
        // wen high is a read
        rdata_q <= mem_q[row_i];
      end else begin
        for (int b = 0; b < LANE_DW / 8; b++) begin
          if (be_i[b]) begin
            mem_q[row_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
          end
        end
      end
    end
  end

  // response for reads and writes alike, one cycle after grant
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i & gnt_o;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;

endmodule

// File: src/tcdm_req_fifo.sv
`timescale 1ns/1ps

module tcdm_req_fifo #(
  parameter int unsigned FIFO_DEPTH = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             in_req_i,
  input  logic                             in_wen_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]      in_addr_i,
  input  tcdm_pkg::wide_be_t               in_be_i,
  input  logic [tcdm_pkg::WIDE_DW-1:0]     in_wdata_i,
  output logic                             in_gnt_o,
  output logic                             out_req_o,
  output logic                             out_wen_o,
  output logic [tcdm_pkg::ADDR_W-1:0]      out_addr_o,
  output tcdm_pkg::wide_be_t               out_be_o,
  output logic [tcdm_pkg::WIDE_DW-1:0]     out_wdata_o,
  input  logic                             out_gnt_i
);
  import tcdm_pkg::*;

  // depth 1 still needs a one-bit pointer
  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full, push, pop;

  // stored requests
  logic [FIFO_DEPTH-1:0]              wen_q;
  logic [FIFO_DEPTH-1:0][ADDR_W-1:0]  addr_q;
  wide_be_t [FIFO_DEPTH-1:0]          be_q;
  logic [FIFO_DEPTH-1:0][WIDE_DW-1:0] wdata_q;

  assign full     = (count_q == CNT_W'(FIFO_DEPTH));
  // accept upstream whenever a slot is free
  assign in_gnt_o = ~full;
  assign push     = in_req_i & in_gnt_o;
  assign pop      = out_req_o & out_gnt_i;

  // head entry is offered until the router grants it
  assign out_req_o   = (count_q != '0);
  assign out_wen_o   = wen_q[rd_ptr_q];
  assign out_addr_o  = addr_q[rd_ptr_q];
  assign out_be_o    = be_q[rd_ptr_q];
  assign out_wdata_o = wdata_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // fill level only moves when exactly one side fires
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      wen_q[wr_ptr_q]   <= in_wen_i;
      addr_q[wr_ptr_q]  <= in_addr_i;
      be_q[wr_ptr_q]    <= in_be_i;
      wdata_q[wr_ptr_q] <= in_wdata_i;
    end
  end

  // pointers meet only when the buffer is empty or full
  a_ptr_count: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_ptr_q == rd_ptr_q) == ((count_q == '0) || full));

endmodule

// File: src/wide_tcdm_top.sv
`timescale 1ns/1ps

module wide_tcdm_top #(
  parameter int unsigned FIFO_DEPTH = 2,
  parameter int unsigned NB_BANKS   = bank_pkg::NB_BANKS,
  parameter int unsigned BANK_WORDS = bank_pkg::BANK_WORDS
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           wide_req_i,
  input  logic                           wide_wen_i,
  input  logic [tcdm_pkg::ADDR_W-1:0]    wide_addr_i,
  input  tcdm_pkg::wide_be_t             wide_be_i,
  input  logic [tcdm_pkg::WIDE_DW-1:0]   wide_wdata_i,
  output logic                           wide_gnt_o,
  output logic                           wide_rvalid_o,
  output logic [tcdm_pkg::WIDE_DW-1:0]   wide_rdata_o
);
  import tcdm_pkg::*;
  import bank_pkg::*;

  // request as seen by the router
  logic               fifo_req, fifo_wen, fifo_gnt;
  logic [ADDR_W-1:0]  fifo_addr;
  wide_be_t           fifo_be;
  logic [WIDE_DW-1:0] fifo_wdata;

  // router to bank wiring
  logic [NB_BANKS-1:0]              bank_req, bank_wen, bank_gnt, bank_rvalid;
  logic [NB_BANKS-1:0][ROW_W-1:0]   bank_row;
  lane_be_t [NB_BANKS-1:0]          bank_be;
  logic [NB_BANKS-1:0][LANE_DW-1:0] bank_wdata, bank_rdata;

  if (FIFO_DEPTH > 0) begin : gen_fifo
    tcdm_req_fifo #(
      .FIFO_DEPTH ( FIFO_DEPTH )
    ) u_req_fifo (
      .clk_i       ( clk_i        ),
      .rst_ni      ( rst_ni       ),
      .in_req_i    ( wide_req_i   ),
      .in_wen_i    ( wide_wen_i   ),
      .in_addr_i   ( wide_addr_i  ),
      .in_be_i     ( wide_be_i    ),
      .in_wdata_i  ( wide_wdata_i ),
      .in_gnt_o    ( wide_gnt_o   ),
      .out_req_o   ( fifo_req     ),
      .out_wen_o   ( fifo_wen     ),
      .out_addr_o  ( fifo_addr    ),
      .out_be_o    ( fifo_be      ),
      .out_wdata_o ( fifo_wdata   ),
      .out_gnt_i   ( fifo_gnt     )
    );
  end else begin : gen_no_fifo
    // router sees the wide port directly, rvalid one cycle after gnt
    assign fifo_req   = wide_req_i;
    assign fifo_wen   = wide_wen_i;
    assign fifo_addr  = wide_addr_i;
    assign fifo_be    = wide_be_i;
    assign fifo_wdata = wide_wdata_i;
    assign wide_gnt_o = fifo_gnt;
  end

  wide_router #(
    .NB_BANKS ( NB_BANKS )
  ) u_router (
    .clk_i         ( clk_i         ),
    .rst_ni        ( rst_ni        ),
    .req_i         ( fifo_req      ),
    .wen_i         ( fifo_wen      ),
    .addr_i        ( fifo_addr     ),
    .be_i          ( fifo_be       ),
    .wdata_i       ( fifo_wdata    ),
    .gnt_o         ( fifo_gnt      ),
    .rvalid_o      ( wide_rvalid_o ),
    .rdata_o       ( wide_rdata_o  ),
    .bank_req_o    ( bank_req      ),
    .bank_wen_o    ( bank_wen      ),
    .bank_row_o    ( bank_row      ),
    .bank_be_o     ( bank_be       ),
    .bank_wdata_o  ( bank_wdata    ),
    .bank_gnt_i    ( bank_gnt      ),
    .bank_rvalid_i ( bank_rvalid   ),
    .bank_rdata_i  ( bank_rdata    )
  );

  for (genvar b = 0; b < NB_BANKS; b++) begin : gen_bank
    tcdm_bank #(
      .BANK_WORDS ( BANK_WORDS )
    ) u_bank (
      .clk_i    ( clk_i          ),
      .rst_ni   ( rst_ni         ),
      .req_i    ( bank_req[b]    ),
      .wen_i    ( bank_wen[b]    ),
      .row_i    ( bank_row[b]    ),
      .be_i     ( bank_be[b]     ),
      .wdata_i  ( bank_wdata[b]  ),
      .gnt_o    ( bank_gnt[b]    ),
      .rvalid_o ( bank_rvalid[b] ),
      .rdata_o  ( bank_rdata[b]  )
    );
  end

endmodule

// File: wide_tcdm.f
common/tcdm_pkg.sv
common/bank_pkg.sv
src/tcdm_req_fifo.sv
router/router_reorder.sv
router/wide_router.sv
src/tcdm_bank.sv
src/wide_tcdm_top.sv
sim/tb_wide_tcdm.sv
